// ==== src/scuDspPkg.sv ====
`default_nettype none

package scuDspPkg;

	localparam int INSTR_W = 32;
	localparam int IMM_W = 24;
	localparam int OPC_W = 4;
	localparam int PC_W = 8;
	localparam int PRG_DEPTH = 1 << PC_W;

	localparam int QUEUE_DEPTH = 4;
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W = QPTR_W + 1;

	// Host register map
	localparam int REG_ADDR_W = 2;
	localparam logic [REG_ADDR_W-1:0] REG_CTRL = 2'd0;
	localparam logic [REG_ADDR_W-1:0] REG_PRG = 2'd1;
	localparam logic [REG_ADDR_W-1:0] REG_AC = 2'd3;

	// Status word, PC sits in the low byte
	localparam int EXEC_BIT = 16;
	localparam int IRQ_BIT = 17;
	localparam int V_BIT = 18;
	localparam int C_BIT = 19;
	localparam int Z_BIT = 20;
	localparam int S_BIT = 21;

	// Control write
	localparam int LOAD_PC_BIT = 15;
	localparam int START_BIT = 16;
	localparam int PAUSE_BIT = 25;
	localparam int RESUME_BIT = 26;

	// Opcode in the top nibble of the word, immediate in the low 24 bits
	typedef enum logic [OPC_W-1:0] {
		OP_NOP,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_ADD,
		OP_SUB,
		OP_SR,
		OP_RR,
		OP_SL,
		OP_RL,
		OP_RL8,
		OP_MVIP,
		OP_MVIA,
		OP_END,
		OP_ENDI
	} opcodeT;

endpackage

`default_nettype wire

// ==== src/instrIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface instrIf;
	import scuDspPkg::*;

	logic             valid;
	logic             ready;
	opcodeT           opcode;
	logic [IMM_W-1:0] imm;

	modport producer (
		output valid,
		output opcode,
		output imm,
		input  ready
	);

	modport consumer (
		input  valid,
		input  opcode,
		input  imm,
		output ready
	);

endinterface

`default_nettype wire

// ==== src/hostPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module hostPort (
	input  wire                              CLK,
	input  wire                              RST_N,
	input  wire [scuDspPkg::REG_ADDR_W-1:0]  addr,
	input  wire [scuDspPkg::INSTR_W-1:0]     wrData,
	input  wire                              wrEn,
	input  wire                              rdEn,
	input  wire [scuDspPkg::PC_W-1:0]        pc,
	input  wire [scuDspPkg::INSTR_W-1:0]     ac,
	input  wire                              flagS,
	input  wire                              flagZ,
	input  wire                              flagC,
	input  wire                              flagV,
	input  wire                              halt,
	input  wire                              raiseIrq,
	output logic [scuDspPkg::INSTR_W-1:0]    rdData,
	output logic                             irq,
	output logic                             running,
	output logic                             accept,
	output logic                             flush,
	output logic                             prgWrite,
	output logic                             loadPc,
	output logic                             vClear
);
	import scuDspPkg::*;

	logic               paused;
	logic               ctrlWrite;
	logic               startWrite;
	logic               statusRead;
	logic [INSTR_W-1:0] status;

	assign ctrlWrite = wrEn && (addr == REG_CTRL);
	assign startWrite = ctrlWrite && wrData[START_BIT] && !running;
	assign statusRead = rdEn && (addr == REG_CTRL);

	assign accept = running && !paused;
	assign flush = halt || startWrite;
	// Program RAM and PC are host-owned only while stopped
	assign prgWrite = wrEn && (addr == REG_PRG) && !running;
	assign loadPc = ctrlWrite && wrData[LOAD_PC_BIT] && !running;
	assign vClear = statusRead;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			running <= 1'b0;
			paused <= 1'b0;
		end else if (halt) begin
			running <= 1'b0;
			paused <= 1'b0;
		end else if (startWrite) begin
			running <= 1'b1;
			paused <= 1'b0;
		end else if (ctrlWrite && running) begin
			// Pause wins over resume
			if (wrData[PAUSE_BIT]) begin
				paused <= 1'b1;
			end else if (wrData[RESUME_BIT]) begin
				paused <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			irq <= 1'b0;
		end else if (raiseIrq) begin
			irq <= 1'b1;
		end else if (statusRead) begin
			irq <= 1'b0;
		end
	end

	always_comb begin
		status = '0;
		status[PC_W-1:0] = pc;
		status[EXEC_BIT] = accept;
		status[IRQ_BIT] = irq;
		status[V_BIT] = flagV;
		status[C_BIT] = flagC;
		status[Z_BIT] = flagZ;
		status[S_BIT] = flagS;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rdData <= '0;
		end else if (rdEn) begin
			case (addr)
				REG_CTRL: rdData <= status;
				REG_AC:   rdData <= ac;
				default:  rdData <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
	input  wire                           CLK,
	input  wire                           RST_N,
	input  wire                           running,
	input  wire                           flush,
	input  wire                           prgWrite,
	input  wire                           loadPc,
	input  wire [scuDspPkg::INSTR_W-1:0]  wrData,
	instrIf.producer                      out,
	output logic [scuDspPkg::PC_W-1:0]    pc
);
	import scuDspPkg::*;

	logic [INSTR_W-1:0] prgRam [PRG_DEPTH];
	logic [INSTR_W-1:0] word;
	logic [PC_W-1:0]    rdAddr;
	logic               wordValid;
	logic               stopped;
	logic               xfer;
	logic               lastWord;

	assign out.valid = wordValid;
	assign out.opcode = opcodeT'(word[INSTR_W-1 -: OPC_W]);
	assign out.imm = word[IMM_W-1:0];

	assign xfer = wordValid && out.ready;
	assign lastWord = (out.opcode == OP_END) || (out.opcode == OP_ENDI);

	// Look one ahead on a transfer so the next word is ready back to back
	assign rdAddr = xfer ? pc + 1'b1 : pc;

	always_ff @(posedge CLK) begin
		if (prgWrite) begin
			prgRam[pc] <= wrData;
		end
		word <= prgRam[rdAddr];
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pc <= '0;
		end else if (loadPc) begin
			pc <= wrData[PC_W-1:0];
		end else if (prgWrite || xfer) begin
			pc <= pc + 1'b1;
		end
	end

	// Stop issuing once END has left, so PC ends one past it
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wordValid <= 1'b0;
			stopped <= 1'b0;
		end else if (flush) begin
			wordValid <= 1'b0;
			stopped <= 1'b0;
		end else begin
			if (xfer && lastWord) begin
				stopped <= 1'b1;
			end
			if (xfer || !wordValid) begin
				wordValid <= running && !stopped && !(xfer && lastWord);
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/instrQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrQueue (
	input  wire       CLK,
	input  wire       RST_N,
	input  wire       flush,
	instrIf.consumer  in,
	instrIf.producer  out
);
	import scuDspPkg::*;

	opcodeT            opMem [QUEUE_DEPTH];
	logic [IMM_W-1:0]  immMem [QUEUE_DEPTH];
	logic [QPTR_W-1:0] wrPtr;
	logic [QPTR_W-1:0] rdPtr;
	logic [QCNT_W-1:0] count;
	logic              push;
	logic              pop;

	// No traffic in the flush cycle
	assign in.ready = (count != QCNT_W'(QUEUE_DEPTH)) && !flush;
	assign out.valid = (count != '0) && !flush;
	assign out.opcode = opMem[rdPtr];
	assign out.imm = immMem[rdPtr];

	assign push = in.valid && in.ready;
	assign pop = out.valid && out.ready;

	always_ff @(posedge CLK) begin
		if (push) begin
			opMem[wrPtr] <= in.opcode;
			immMem[wrPtr] <= in.imm;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else if (flush) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/executeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
	input  wire                           CLK,
	input  wire                           RST_N,
	input  wire                           accept,
	input  wire                           vClear,
	instrIf.consumer                      in,
	output logic [scuDspPkg::INSTR_W-1:0] ac,
	output logic                          flagS,
	output logic                          flagZ,
	output logic                          flagC,
	output logic                          flagV,
	output logic                          halt,
	output logic                          raiseIrq
);
	import scuDspPkg::*;

	logic [INSTR_W-1:0] p;
	logic [INSTR_W-1:0] immExt;
	logic [INSTR_W-1:0] result;
	logic               carry;
	logic               overflow;
	logic               aluOp;
	logic               xfer;

	assign in.ready = accept;
	assign xfer = in.valid && accept;
	assign immExt = {{(INSTR_W - IMM_W){in.imm[IMM_W-1]}}, in.imm};

	always_comb begin
		result = ac;
		carry = 1'b0;
		overflow = 1'b0;
		aluOp = 1'b1;
		case (in.opcode)
			OP_AND: result = ac & p;
			OP_OR:  result = ac | p;
			OP_XOR: result = ac ^ p;
			OP_ADD: begin
				{carry, result} = {1'b0, ac} + {1'b0, p};
				overflow = ~(ac[INSTR_W-1] ^ p[INSTR_W-1]) & (ac[INSTR_W-1] ^ result[INSTR_W-1]);
			end
			OP_SUB: begin
				// Carry holds the borrow
				{carry, result} = {1'b0, ac} - {1'b0, p};
				overflow = (ac[INSTR_W-1] ^ p[INSTR_W-1]) & (ac[INSTR_W-1] ^ result[INSTR_W-1]);
			end
			OP_SR:  {result, carry} = {ac[INSTR_W-1], ac};
			OP_RR:  {result, carry} = {ac[0], ac};
			OP_SL:  {carry, result} = {ac, 1'b0};
			OP_RL:  {carry, result} = {ac, ac[INSTR_W-1]};
			OP_RL8: {carry, result} = {ac[24:0], ac[31:24]};
			default: aluOp = 1'b0;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ac <= '0;
			p <= '0;
			flagS <= 1'b0;
			flagZ <= 1'b0;
			flagC <= 1'b0;
		end else if (xfer) begin
			if (aluOp) begin
				ac <= result;
				flagS <= result[INSTR_W-1];
				flagZ <= (result == '0);
				flagC <= carry;
			end
			if (in.opcode == OP_MVIA) begin
				ac <= immExt;
			end
			if (in.opcode == OP_MVIP) begin
				p <= immExt;
			end
		end
	end

	// Sticky until the host reads status
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			flagV <= 1'b0;
		end else begin
			flagV <= (flagV && !vClear) || (xfer && overflow);
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			halt <= 1'b0;
			raiseIrq <= 1'b0;
		end else begin
			halt <= xfer && ((in.opcode == OP_END) || (in.opcode == OP_ENDI));
			raiseIrq <= xfer && (in.opcode == OP_ENDI);
		end
	end

endmodule

`default_nettype wire

// ==== src/scuDsp.sv ====
`timescale 1ns/1ps
`default_nettype none

module scuDsp (
	input  wire                              CLK,
	input  wire                              RST_N,
	input  wire [scuDspPkg::REG_ADDR_W-1:0]  addr,
	input  wire [scuDspPkg::INSTR_W-1:0]     wrData,
	input  wire                              wrEn,
	input  wire                              rdEn,
	output logic [scuDspPkg::INSTR_W-1:0]    rdData,
	output logic                             irq
);
	import scuDspPkg::*;

	logic               running;
	logic               accept;
	logic               flush;
	logic               prgWrite;
	logic               loadPc;
	logic               vClear;
	logic               halt;
	logic               raiseIrq;
	logic [PC_W-1:0]    pc;
	logic [INSTR_W-1:0] ac;
	logic               flagS;
	logic               flagZ;
	logic               flagC;
	logic               flagV;

	instrIf fetchBus ();
	instrIf execBus ();

	hostPort i_hostPort (
		.CLK(CLK),
		.RST_N(RST_N),
		.addr(addr),
		.wrData(wrData),
		.wrEn(wrEn),
		.rdEn(rdEn),
		.pc(pc),
		.ac(ac),
		.flagS(flagS),
		.flagZ(flagZ),
		.flagC(flagC),
		.flagV(flagV),
		.halt(halt),
		.raiseIrq(raiseIrq),
		.rdData(rdData),
		.irq(irq),
		.running(running),
		.accept(accept),
		.flush(flush),
		.prgWrite(prgWrite),
		.loadPc(loadPc),
		.vClear(vClear)
	);

	fetchUnit i_fetchUnit (
		.CLK(CLK),
		.RST_N(RST_N),
		.running(running),
		.flush(flush),
		.prgWrite(prgWrite),
		.loadPc(loadPc),
		.wrData(wrData),
		.out(fetchBus.producer),
		.pc(pc)
	);

	instrQueue i_instrQueue (
		.CLK(CLK),
		.RST_N(RST_N),
		.flush(flush),
		.in(fetchBus.consumer),
		.out(execBus.producer)
	);

	executeUnit i_executeUnit (
		.CLK(CLK),
		.RST_N(RST_N),
		.accept(accept),
		.vClear(vClear),
		.in(execBus.consumer),
		.ac(ac),
		.flagS(flagS),
		.flagZ(flagZ),
		.flagC(flagC),
		.flagV(flagV),
		.halt(halt),
		.raiseIrq(raiseIrq)
	);

endmodule

`default_nettype wire

// ==== verification/scuDsp_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module scuDsp_asserts (
	input wire                          CLK,
	input wire                          RST_N,
	input wire                          flush,
	input wire                          inValid,
	input wire                          inReady,
	input wire                          outValid,
	input wire                          outReady,
	input wire [scuDspPkg::QCNT_W-1:0] count
);

	// Fetch side holds its word while the queue is full
	assert property (@(posedge CLK) disable iff (!RST_N)
		(inValid && !inReady && !flush) |=> inValid)
		else $error("fetch valid dropped before transfer");

	// Empty with no push leaves nothing to pop next cycle
	assert property (@(posedge CLK) disable iff (!RST_N)
		(count == '0 && !(inValid && inReady)) |=> !(outValid && outReady))
		else $error("pop from an empty queue");

	assert property (@(posedge CLK) disable iff (!RST_N)
		flush |=> (count == '0))
		else $error("queue not empty after flush");

endmodule

`default_nettype wire

// ==== verification/scuDspTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scuDspTb;
	import scuDspPkg::*;

	localparam int NROWS = 10;
	localparam int WAIT_MAX = 500;

	logic                  CLK;
	logic                  RST_N;
	logic [REG_ADDR_W-1:0] addr;
	logic [INSTR_W-1:0]    wrData;
	logic                  wrEn;
	logic                  rdEn;
	logic [INSTR_W-1:0]    rdData;
	logic                  irq;

	string        names [NROWS];
	logic [31:0]  progs [NROWS][8];
	int           lens [NROWS];
	bit           pauses [NROWS];
	logic [31:0]  expAc [NROWS];
	logic [3:0]   expFlags [NROWS];
	bit           expIrq [NROWS];
	int           errors;
	int           rowErr;
	int           passCount;
	bit           timedOut;

	scuDsp i_scuDsp (
		.CLK(CLK),
		.RST_N(RST_N),
		.addr(addr),
		.wrData(wrData),
		.wrEn(wrEn),
		.rdEn(rdEn),
		.rdData(rdData),
		.irq(irq)
	);

	bind instrQueue scuDsp_asserts i_queueAsserts (
		.CLK(CLK),
		.RST_N(RST_N),
		.flush(flush),
		.inValid(in.valid),
		.inReady(in.ready),
		.outValid(out.valid),
		.outReady(out.ready),
		.count(count)
	);

	always #20 CLK = ~CLK;

	function automatic logic [31:0] enc(opcodeT op, logic [23:0] imm);
		return {op, 4'b0, imm};
	endfunction

	task automatic writeReg(logic [1:0] a, logic [31:0] d);
		addr = a;
		wrData = d;
		wrEn = 1'b1;
		@(negedge CLK);
		wrEn = 1'b0;
	endtask

	task automatic readReg(logic [1:0] a, output logic [31:0] d);
		addr = a;
		rdEn = 1'b1;
		@(negedge CLK);
		rdEn = 1'b0;
		d = rdData;
	endtask

	task automatic compareValue(string testName, string what, logic [31:0] exp, logic [31:0] act);
		assert (exp === act) else begin
			$display("error %s %s expected %h actual %h", testName, what, exp, act);
			rowErr++;
		end
	endtask

	task automatic setRow(int r, string n, bit pz, logic [31:0] a, logic [3:0] f, bit i);
		names[r] = n;
		pauses[r] = pz;
		expAc[r] = a;
		expFlags[r] = f;
		expIrq[r] = i;
	endtask

	// Reference model from the ALU rules, covers the ops of the random row
	task automatic modelRow(int r);
		logic [31:0] mAc;
		logic [31:0] mP;
		logic [32:0] sum;
		logic [31:0] imm;
		logic        c;
		logic        v;
		c = 1'b0;
		v = 1'b0;
		mAc = '0;
		mP = '0;
		for (int i = 0; i < lens[r]; i++) begin
			imm = {{8{progs[r][i][23]}}, progs[r][i][23:0]};
			case (opcodeT'(progs[r][i][31:28]))
				OP_MVIA: mAc = imm;
				OP_MVIP: mP = imm;
				OP_ADD: begin
					sum = {1'b0, mAc} + {1'b0, mP};
					v |= (mAc[31] == mP[31]) && (sum[31] != mAc[31]);
					c = sum[32];
					mAc = sum[31:0];
				end
				OP_SUB: begin
					sum = {1'b0, mAc - mP};
					v |= (mAc[31] != mP[31]) && (sum[31] != mAc[31]);
					c = mAc < mP;
					mAc = sum[31:0];
				end
				OP_XOR: begin
					mAc = mAc ^ mP;
					c = 1'b0;
				end
				OP_RL: begin
					c = mAc[31];
					mAc = {mAc[30:0], mAc[31]};
				end
				default: ;
			endcase
		end
		expAc[r] = mAc;
		expFlags[r] = {mAc[31], mAc == '0, c, v};
	endtask

	task automatic fillTable();
		progs[0] = '{enc(OP_MVIA, 24'hF0F0F0), enc(OP_MVIP, 24'h0FFFFF), enc(OP_AND, 0),
			enc(OP_MVIP, 24'hFFFFFF), enc(OP_XOR, 0), enc(OP_END, 0), 0, 0};
		setRow(0, "andXor", 0, 32'hFFFF0F0F, 4'b1000, 0);
		progs[1] = '{enc(OP_MVIA, 24'h123456), enc(OP_MVIP, 24'h123456), enc(OP_XOR, 0),
			enc(OP_OR, 0), enc(OP_XOR, 0), enc(OP_END, 0), 0, 0};
		setRow(1, "orXorZero", 0, 32'h0, 4'b0100, 0);
		progs[2] = '{enc(OP_MVIA, 24'hFFFFFF), enc(OP_MVIP, 24'h000001), enc(OP_ADD, 0),
			enc(OP_END, 0), 0, 0, 0, 0};
		setRow(2, "addCarry", 0, 32'h0, 4'b0110, 0);
		progs[3] = '{enc(OP_MVIA, 24'h000001), enc(OP_MVIP, 24'h000002), enc(OP_SUB, 0),
			enc(OP_END, 0), 0, 0, 0, 0};
		setRow(3, "subBorrow", 0, 32'hFFFFFFFF, 4'b1010, 0);
		progs[4] = '{enc(OP_MVIA, 24'h800000), enc(OP_RL8, 0), enc(OP_MVIP, 24'h7FFFFF),
			enc(OP_SUB, 0), enc(OP_MVIP, 24'h000001), enc(OP_ADD, 0), enc(OP_ENDI, 0), 0};
		setRow(4, "overflowSticky", 0, 32'h7F800101, 4'b0001, 1);
		progs[5] = '{enc(OP_MVIA, 24'h800003), enc(OP_SR, 0), enc(OP_RR, 0),
			enc(OP_END, 0), 0, 0, 0, 0};
		setRow(5, "shiftRight", 0, 32'hFFE00000, 4'b1010, 0);
		progs[6] = '{enc(OP_MVIA, 24'h400001), enc(OP_SL, 0), enc(OP_RL8, 0), enc(OP_RL, 0),
			enc(OP_END, 0), 0, 0, 0};
		setRow(6, "shiftLeft", 0, 32'h00000401, 4'b0010, 0);
		progs[7] = '{enc(OP_MVIA, 24'h000005), enc(OP_MVIP, 0), enc(OP_OR, 0),
			enc(OP_ENDI, 0), 0, 0, 0, 0};
		setRow(7, "endiIrq", 0, 32'h5, 4'b0000, 1);
		progs[8] = progs[4];
		setRow(8, "pausedOverflow", 1, 32'h7F800101, 4'b0001, 1);
		progs[9] = '{enc(OP_MVIA, 24'($urandom)), enc(OP_MVIP, 24'($urandom)), enc(OP_ADD, 0),
			enc(OP_MVIP, 24'($urandom)), enc(OP_SUB, 0), enc(OP_XOR, 0), enc(OP_RL, 0),
			enc(OP_ENDI, 0)};
		setRow(9, "randomAlu", 0, 0, 0, 1);
		for (int r = 0; r < NROWS; r++) begin
			lens[r] = 8;
			for (int i = 7; i >= 0; i--) begin
				if (progs[r][i][31:28] == OP_END || progs[r][i][31:28] == OP_ENDI) begin
					lens[r] = i + 1;
				end
			end
		end
		modelRow(9);
	endtask

	task automatic runRow(int r);
		logic [31:0] st;
		logic [31:0] acv;
		logic [7:0]  base;
		int          k;
		base = 8'(r * 20);
		writeReg(REG_CTRL, (32'd1 << LOAD_PC_BIT) | base);
		for (int i = 0; i < lens[r]; i++) begin
			writeReg(REG_PRG, progs[r][i]);
		end
		writeReg(REG_CTRL, (32'd1 << LOAD_PC_BIT) | base);
		writeReg(REG_CTRL, 32'd1 << START_BIT);
		if (pauses[r]) begin
			writeReg(REG_CTRL, 32'd1 << PAUSE_BIT);
			repeat (25) @(negedge CLK);
			// Queue full, fetch holds the next word
			readReg(REG_CTRL, st);
			compareValue(names[r], "exec while paused", 0, 32'(st[EXEC_BIT]));
			compareValue(names[r], "pc while paused", 32'(base + 8'(QUEUE_DEPTH)),
				32'(st[7:0]));
			writeReg(REG_CTRL, 32'd1 << RESUME_BIT);
		end
		st = '0;
		if (expIrq[r]) begin
			// Wait on the pin so polling does not clear V early
			for (k = 0; k < WAIT_MAX && !irq; k++) @(negedge CLK);
			if (!irq) begin
				$display("timeout in %s: irq never rose", names[r]);
				timedOut = 1'b1;
				return;
			end
			readReg(REG_CTRL, st);
		end else begin
			st[EXEC_BIT] = 1'b1;
			for (k = 0; k < WAIT_MAX && st[EXEC_BIT]; k++) readReg(REG_CTRL, st);
			if (st[EXEC_BIT]) begin
				$display("timeout in %s: program never stopped", names[r]);
				timedOut = 1'b1;
				return;
			end
		end
		readReg(REG_AC, acv);
		compareValue(names[r], "ac", expAc[r], acv);
		compareValue(names[r], "flags SZCV", 32'(expFlags[r]), 32'(st[S_BIT -: 4]));
		compareValue(names[r], "irq", 32'(expIrq[r]), 32'(st[IRQ_BIT]));
		compareValue(names[r], "pc", 32'(base + 8'(lens[r])), 32'(st[7:0]));
		if (expIrq[r]) begin
			readReg(REG_CTRL, st);
			compareValue(names[r], "irq after read", 0, 32'(st[IRQ_BIT]));
			compareValue(names[r], "v after read", 0, 32'(st[V_BIT]));
			compareValue(names[r], "irq pin", 0, 32'(irq));
		end
	endtask

	initial begin
		CLK = 1'b0;
		RST_N = 1'b0;
		addr = '0;
		wrData = '0;
		wrEn = 1'b0;
		rdEn = 1'b0;
		errors = 0;
		passCount = 0;
		timedOut = 1'b0;
		void'($urandom(32'h115f_b00c));
		fillTable();
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
		@(negedge CLK);
		for (int r = 0; r < NROWS && !timedOut; r++) begin
			rowErr = 0;
			runRow(r);
			if (timedOut) rowErr++;
			errors += rowErr;
			if (rowErr == 0) passCount++;
			$display("%s: %s", names[r], (rowErr == 0) ? "ok" : "FAIL");
		end
		$display("summary: %0d passed, %0d with errors", passCount, NROWS - passCount);
		if (errors == 0 && !timedOut) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== scuDsp.f ====
src/scuDspPkg.sv
src/instrIf.sv
src/hostPort.sv
src/fetchUnit.sv
src/instrQueue.sv
src/executeUnit.sv
src/scuDsp.sv
verification/scuDsp_asserts.sv
verification/scuDspTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module scuDspTb -f scuDsp.f -o scuDspSim

./obj_dir/scuDspSim | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "all tests passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
